/* rtl/his_cfg_pkg.sv */
package his_cfg_pkg;

    // bins in one pixel histogram
    localparam int BIN_NUM = 16;
    // bin number width
    localparam int BIN_W = 4;

    // pixels sharing one count memory
    localparam int PIXEL_NUM = 4;
    localparam int PIXEL_W = 2;

    // hits per pixel per acquisition
    localparam int DATA_NUM = 8;
    localparam int DATA_W = 3;

    // acquisitions per frame
    localparam int ACQ_NUM = 2;
    localparam int ACQ_W = 1;

    // total hits needed to close one frame
    localparam int HITS_PER_FRAME = DATA_NUM * PIXEL_NUM * ACQ_NUM;

    // one bin count, saturating at the top
    localparam int COUNT_W = 6;
    localparam int COUNT_MAX = (1 << COUNT_W) - 1;

    // words in one bank, pixel-major
    localparam int WORDS_PER_BANK = PIXEL_NUM * BIN_NUM;
    // address inside one bank, pixel then bin
    localparam int ADDR_W = PIXEL_W + BIN_W;

    // fill bank plus read-out bank
    localparam int BANK_NUM = 2;

    // cycles between frame end and first read
    // lets the last increment land in memory
    localparam int RD_WAIT = 2;

endpackage

/* rtl/his_types_pkg.sv */
package his_types_pkg;

    // one accepted hit, stamped by the frame counter
    // bank bit sits on top so the whole struct
    // doubles as the memory index
    typedef struct packed {
        // fill bank at the time of the hit
        logic                              bank;
        // pixel the hit belongs to
        logic [his_cfg_pkg::PIXEL_W-1:0]   pixel;
        // timing bin
        logic [his_cfg_pkg::BIN_W-1:0]     bin;
    } hit_t;

    // one histogram word from the read-out
    // pixel and bin tell where the count came from
    typedef struct packed {
        // source pixel
        logic [his_cfg_pkg::PIXEL_W-1:0]   pixel;
        // source bin
        logic [his_cfg_pkg::BIN_W-1:0]     bin;
        // saturated hit count
        logic [his_cfg_pkg::COUNT_W-1:0]   count;
    } his_word_t;

endpackage

/* rtl/his_frame_counter.sv */
`timescale 1ns/100ps

module his_frame_counter (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            hit_en,
    input  logic [his_cfg_pkg::BIN_W-1:0]   hit_bin,
    output logic                            hit_stb,
    output his_types_pkg::hit_t             hit,
    output logic                            frame_done,
    output logic                            his_num
);
    import his_cfg_pkg::*;

    // hit count within the current pixel
    logic [DATA_W-1:0]  data_cnt;
    // pixel within the current acquisition
    logic [PIXEL_W-1:0] pix_cnt;
    // acquisition within the current frame
    logic [ACQ_W-1:0]   acq_cnt;

    logic data_last;
    logic pix_last;
    logic acq_last;
    logic frame_last;

    // wrap points of the three nested counters
    assign data_last = data_cnt == DATA_W'(DATA_NUM - 1);
    assign pix_last = pix_cnt == PIXEL_W'(PIXEL_NUM - 1);
    assign acq_last = acq_cnt == ACQ_W'(ACQ_NUM - 1);
    // accepted hit that closes the frame
    assign frame_last = hit_en && data_last && pix_last && acq_last;

    // every hit_en is taken, no stall
    assign hit_stb = hit_en;

    // stamp from registered state only
    always_comb begin
        hit.bank = his_num;
        hit.pixel = pix_cnt;
        hit.bin = hit_bin;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            data_cnt <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (hit_en) begin
            // inner counter always steps
            data_cnt <= data_last ? '0 : data_cnt + 1'b1;
            // pixel steps when a pixel has all its hits
            if (data_last) begin
                pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
            end
            // acquisition steps after the last pixel
            if (data_last && pix_last) begin
                acq_cnt <= acq_last ? '0 : acq_cnt + 1'b1;
            end
        end
    end

    // bank toggle and one-cycle done pulse
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            his_num <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= frame_last;
            if (frame_last) begin
                his_num <= ~his_num;
            end
        end
    end

endmodule

/* rtl/his_bin_ram.sv */
`timescale 1ns/100ps

module his_bin_ram (
    input  logic                              clk,
    input  logic                              res,
    input  logic                              hit_stb,
    input  his_types_pkg::hit_t               hit,
    input  logic                              rd_stb,
    input  logic [his_cfg_pkg::ADDR_W-1:0]    rd_addr,
    output logic [his_cfg_pkg::COUNT_W-1:0]   rd_count
);
    import his_cfg_pkg::*;

    // both banks in one array, bank bit on top
    logic [COUNT_W-1:0] mem [BANK_NUM * WORDS_PER_BANK];

    // full index of the incoming hit
    logic [ADDR_W:0]    hit_idx;
    // full index of the read-out access
    logic [ADDR_W:0]    rd_idx;

    // increment pipeline, one hit in flight
    logic               p_vld;
    logic [ADDR_W:0]    p_idx;
    logic [COUNT_W-1:0] p_cnt;
    logic [COUNT_W-1:0] p_inc;

    // count seen by the incoming hit
    logic [COUNT_W-1:0] old_cnt;
    logic               fwd_hit;

    // plus one, held at the top
    function automatic logic [COUNT_W-1:0] sat_inc(input logic [COUNT_W-1:0] cnt);
        if (cnt == COUNT_W'(COUNT_MAX)) begin
            return cnt;
        end
        return cnt + 1'b1;
    endfunction

    assign hit_idx = {hit.bank, hit.pixel, hit.bin};

    // read-out always targets the bank not being filled
    assign rd_idx = {~hit.bank, rd_addr};

    // value written by the stage-two edge
    assign p_inc = sat_inc(p_cnt);

    // same bank and address still in flight
    // take the pending result, memory is one write behind
    assign fwd_hit = p_vld && (p_idx == hit_idx);
    assign old_cnt = fwd_hit ? p_inc : mem[hit_idx];

    // stage one valid
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            p_vld <= 1'b0;
        end else begin
            p_vld <= hit_stb;
        end
    end

    // stage one payload, old count and where it goes
    always_ff @(posedge clk) begin
        if (hit_stb) begin
            p_idx <= hit_idx;
            p_cnt <= old_cnt;
        end
    end

    // memory writes
    // increment lands one edge after the hit
    // read port clears what it returns
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < BANK_NUM * WORDS_PER_BANK; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (p_vld) begin
                mem[p_idx] <= p_inc;
            end
            // clear wins on a clash, only seen after overrun
            if (rd_stb) begin
                mem[rd_idx] <= '0;
            end
        end
    end

    // read data one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rd_stb) begin
            rd_count <= mem[rd_idx];
        end
    end

endmodule

/* rtl/his_readout.sv */
`timescale 1ns/100ps

module his_readout (
    input  logic                              clk,
    input  logic                              res,
    input  logic                              frame_done,
    input  logic                              his_num,
    input  logic [his_cfg_pkg::COUNT_W-1:0]   rd_count,
    output logic                              rd_stb,
    output logic [his_cfg_pkg::ADDR_W-1:0]    rd_addr,
    output logic                              his_valid,
    output his_types_pkg::his_word_t          his_word,
    output logic                              overrun
);
    import his_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_SCAN
    } state_t;

    state_t            state;
    // landing delay counter
    logic [0:0]        wait_cnt;
    // fill bank seen at scan start
    logic              scan_fill;
    logic [ADDR_W-1:0] scan_addr;
    // address of the word now on rd_count
    logic [ADDR_W-1:0] word_addr;
    logic              scan_last;
    logic              bank_moved;

    // fill bank toggled again mid scan
    // the idle bank is no longer ours, stop reading
    assign bank_moved = his_num != scan_fill;
    assign scan_last = scan_addr == ADDR_W'(WORDS_PER_BANK - 1);

    assign rd_stb = (state == ST_SCAN) && !bank_moved;
    assign rd_addr = scan_addr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= ST_IDLE;
            wait_cnt <= '0;
            scan_fill <= 1'b0;
            scan_addr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_done) begin
                        state <= ST_WAIT;
                        wait_cnt <= '0;
                        scan_fill <= his_num;
                        scan_addr <= '0;
                    end
                end
                ST_WAIT: begin
                    if (bank_moved) begin
                        state <= ST_IDLE;
                    end else if (wait_cnt == 1'(RD_WAIT - 1)) begin
                        state <= ST_SCAN;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_SCAN: begin
                    // pixel-major, bins ascending
                    if (bank_moved || scan_last) begin
                        state <= ST_IDLE;
                    end
                    scan_addr <= scan_addr + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // frame end while busy, sticky until reset
    // the new frame is not scanned
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            overrun <= 1'b0;
        end else if (frame_done && (state != ST_IDLE)) begin
            overrun <= 1'b1;
        end
    end

    // word valid follows the read strobe by one cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            his_valid <= 1'b0;
        end else begin
            his_valid <= rd_stb;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_stb) begin
            word_addr <= rd_addr;
        end
    end

    // pair returned count with its address
    always_comb begin
        his_word.pixel = word_addr[BIN_W +: PIXEL_W];
        his_word.bin = word_addr[BIN_W-1:0];
        his_word.count = rd_count;
    end

endmodule

/* rtl/his_builder_top.sv */
`timescale 1ns/100ps

module his_builder_top (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            hit_en,
    input  logic [his_cfg_pkg::BIN_W-1:0]   hit_bin,
    output logic                            his_num,
    output logic                            frame_done,
    output logic                            his_valid,
    output his_types_pkg::his_word_t        his_word,
    output logic                            overrun
);
    import his_cfg_pkg::*;
    import his_types_pkg::*;

    // stamped hit into the count memory
    logic               hit_stb;
    hit_t               hit;

    // read-out port of the count memory
    logic               rd_stb;
    logic [ADDR_W-1:0]  rd_addr;
    logic [COUNT_W-1:0] rd_count;

    // counters, bank toggle, frame end
    his_frame_counter his_frame_counter_inst (
        .clk        (clk),
        .res        (res),
        .hit_en     (hit_en),
        .hit_bin    (hit_bin),
        .hit_stb    (hit_stb),
        .hit        (hit),
        .frame_done (frame_done),
        .his_num    (his_num)
    );

    // two banks, saturating increment, clear on read
    his_bin_ram his_bin_ram_inst (
        .clk      (clk),
        .res      (res),
        .hit_stb  (hit_stb),
        .hit      (hit),
        .rd_stb   (rd_stb),
        .rd_addr  (rd_addr),
        .rd_count (rd_count)
    );

    // scans the finished bank after each frame
    his_readout his_readout_inst (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .his_num    (his_num),
        .rd_count   (rd_count),
        .rd_stb     (rd_stb),
        .rd_addr    (rd_addr),
        .his_valid  (his_valid),
        .his_word   (his_word),
        .overrun    (overrun)
    );

endmodule

/* dv/his_builder_tests.svh */
`ifndef HIS_BUILDER_TESTS_SVH
`define HIS_BUILDER_TESTS_SVH

// all flags low, fill bank 0
task automatic test_reset_values();
    start_test();
    @(negedge clk);
    check_value("his_num", 32'(his_num), 0, t_checks, t_errs);
    check_value("frame_done", 32'(frame_done), 0, t_checks, t_errs);
    check_value("his_valid", 32'(his_valid), 0, t_checks, t_errs);
    check_value("overrun", 32'(overrun), 0, t_checks, t_errs);
    report_test("reset_values");
endtask

// spread bins, idle gap after every second hit
task automatic test_known_frame();
    start_test();
    for (int i = 0; i < HITS_PER_FRAME; i++) begin
        send_hit((i * 7 + 3) % BIN_NUM);
        if (i % 2 == 1) begin
            idle_cycles(1);
        end
    end
    end_frame();
    report_test("known_frame");
endtask

// one bin, back to back, so each hit meets the previous one in flight
task automatic test_same_bin();
    start_test();
    for (int i = 0; i < HITS_PER_FRAME; i++) begin
        send_hit(5);
    end
    end_frame();
    // every hit of a pixel over both acquisitions
    for (int p = 0; p < PIXEL_NUM; p++) begin
        check_value("his_word.count", last_scan[p * BIN_NUM + 5], DATA_NUM * ACQ_NUM,
                    t_checks, t_errs);
    end
    report_test("same_bin");
endtask

// first bank again, only bins the known frame left behind would differ
task automatic test_clear_on_read();
    start_test();
    check_value("his_num", 32'(his_num), 0, t_checks, t_errs);
    for (int i = 0; i < HITS_PER_FRAME; i++) begin
        send_hit((i % 4) * 4 + 2);
        if (i % 3 == 0) begin
            idle_cycles(1);
        end
    end
    end_frame();
    report_test("clear_on_read");
endtask

task automatic test_random_frame();
    start_test();
    for (int i = 0; i < HITS_PER_FRAME; i++) begin
        send_hit($urandom_range(BIN_NUM - 1, 0));
        // zero or one idle cycle
        if ($urandom_range(1, 0) == 1) begin
            idle_cycles(1);
        end
    end
    end_frame();
    report_test("random_frame");
endtask

// second frame closes while the first one is still being scanned
task automatic test_overrun();
    int n;
    start_test();
    for (int i = 0; i < 2 * HITS_PER_FRAME; i++) begin
        send_hit(i % BIN_NUM);
    end
    idle_cycles(1);
    n = 0;
    while (!overrun && n < 8) begin
        @(negedge clk);
        n++;
    end
    check_value("overrun", 32'(overrun), 1, t_checks, t_errs);
    // still set, and the dropped frame never shows up
    idle_cycles(40);
    @(negedge clk);
    check_value("overrun", 32'(overrun), 1, t_checks, t_errs);
    check_value("his_valid", 32'(his_valid), 0, t_checks, t_errs);
    apply_reset();
    @(negedge clk);
    check_value("overrun", 32'(overrun), 0, t_checks, t_errs);
    report_test("overrun");
endtask

`endif

/* dv/his_builder_tb.sv */
`timescale 1ns/100ps

module his_builder_tb;
    import his_cfg_pkg::*;
    import his_types_pkg::*;

    // six tests of at most about 250 cycles each, with margin
    localparam int MAX_CYCLES = 2000;

    logic             clk = 1'b0;
    logic             res;
    logic             hit_en;
    logic [BIN_W-1:0] hit_bin;
    logic             his_num;
    logic             frame_done;
    logic             his_valid;
    logic             overrun;
    his_word_t        his_word;

    // expected counts per bank, pixel-major like the scan
    int exp_cnt [BANK_NUM][WORDS_PER_BANK];
    // model frame position, same nesting as the hit counters
    int m_data, m_pix, m_acq, m_bank;
    // scan tracking on the checker side
    int scan_bank, word_idx, scans_done, frame_pulses;
    int last_scan [WORDS_PER_BANK];
    // tallies, checker process and test process apart
    int m_checks, m_errs, t_checks, t_errs;
    // snapshot taken when a test starts
    int errs0, num0, pulses0, scans0;
    int n_tests, cycle_cnt;

    his_builder_top his_builder_top_inst (
        .clk        (clk),
        .res        (res),
        .hit_en     (hit_en),
        .hit_bin    (hit_bin),
        .his_num    (his_num),
        .frame_done (frame_done),
        .his_valid  (his_valid),
        .his_word   (his_word),
        .overrun    (overrun)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int checks, inout int errs);
        checks++;
        if (got !== exp) begin
            errs++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // memory clears on reset, fill bank back to 0
    task automatic model_clear();
        foreach (exp_cnt[b, a]) begin
            exp_cnt[b][a] = 0;
        end
        m_data = 0;
        m_pix = 0;
        m_acq = 0;
        m_bank = 0;
        word_idx = 0;
    endtask

    task automatic model_hit(input int bin);
        int a;
        a = m_pix * BIN_NUM + bin;
        // held at the top of the count width
        if (exp_cnt[m_bank][a] < COUNT_MAX) begin
            exp_cnt[m_bank][a]++;
        end
        m_data++;
        if (m_data == DATA_NUM) begin
            m_data = 0;
            m_pix++;
        end
        if (m_pix == PIXEL_NUM) begin
            m_pix = 0;
            m_acq++;
        end
        // frame complete, other bank fills next
        if (m_acq == ACQ_NUM) begin
            m_acq = 0;
            m_bank = 1 - m_bank;
        end
    endtask

    task automatic check_word();
        int exp_pix;
        int exp_bin;
        // scan reads the bank that just finished
        if (word_idx == 0) begin
            scan_bank = 1 - m_bank;
        end
        exp_pix = word_idx / BIN_NUM;
        exp_bin = word_idx % BIN_NUM;
        check_value("his_word.pixel", 32'(his_word.pixel), exp_pix, m_checks, m_errs);
        check_value("his_word.bin", 32'(his_word.bin), exp_bin, m_checks, m_errs);
        check_value("his_word.count", 32'(his_word.count), exp_cnt[scan_bank][word_idx],
                    m_checks, m_errs);
        last_scan[word_idx] = int'(his_word.count);
        // read clears the location
        exp_cnt[scan_bank][word_idx] = 0;
        word_idx++;
        if (word_idx == WORDS_PER_BANK) begin
            word_idx = 0;
            scans_done++;
        end
    endtask

    // model and checker follow the inputs the DUT samples on this edge
    always @(posedge clk) begin
        if (!res) begin
            model_clear();
        end else begin
            if (frame_done) begin
                frame_pulses++;
            end
            if (his_valid) begin
                check_word();
            end
            if (hit_en) begin
                model_hit(int'(hit_bin));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run reached %0d cycles without finishing", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        res <= 1'b0;
        hit_en <= 1'b0;
        repeat (4) @(posedge clk);
        res <= 1'b1;
    endtask

    task automatic send_hit(input int bin);
        @(posedge clk);
        hit_en <= 1'b1;
        hit_bin <= BIN_W'(bin);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            hit_en <= 1'b0;
        end
    endtask

    task automatic start_test();
        errs0 = t_errs + m_errs;
        num0 = int'(his_num);
        pulses0 = frame_pulses;
        scans0 = scans_done;
    endtask

    // last hit in, whole scan out, then one pulse and a bank toggle
    task automatic end_frame();
        idle_cycles(1);
        while (scans_done == scans0) @(negedge clk);
        check_value("frame_done pulses", frame_pulses - pulses0, 1, t_checks, t_errs);
        check_value("his_num", 32'(his_num), 1 - num0, t_checks, t_errs);
    endtask

    task automatic report_test(input string name);
        n_tests++;
        $display("test %s: %0d errors", name, t_errs + m_errs - errs0);
    endtask

    `include "his_builder_tests.svh"

    initial begin
        res = 1'b0;
        hit_en = 1'b0;
        hit_bin = '0;
        void'($urandom(62));
        apply_reset();
        test_reset_values();
        test_known_frame();
        test_same_bin();
        test_clear_on_read();
        test_random_frame();
        test_overrun();
        $display("tests %0d, checks %0d, errors %0d", n_tests, t_checks + m_checks,
                 t_errs + m_errs);
        if (t_errs + m_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+dv
rtl/his_cfg_pkg.sv
rtl/his_types_pkg.sv
rtl/his_frame_counter.sv
rtl/his_bin_ram.sv
rtl/his_readout.sv
rtl/his_builder_top.sv
dv/his_builder_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the histogram builder testbench with Verilator
# the result comes from the simulation log

verilator --binary --timing --top-module his_builder_tb -f vlog.f -o his_builder_sim \
    && ./obj_dir/his_builder_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log

grep -q "FAIL: see errors above" sim.log \
    && { echo "simulation reported failure"; exit 1; } \
    || grep -q "PASS: all tests" sim.log \
    || { echo "no result found in sim.log"; exit 1; }

exit 0
